/* rvj1_defines.sv */
package rvj1_defines;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  // Only the low bits of op_b count for shifts
  localparam int SHAMT_W    = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // ALU operation select, shared by decoder, interface and ALU
  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'd0,
    ALU_OP_SUB  = 4'd1,
    ALU_OP_XOR  = 4'd2,
    ALU_OP_OR   = 4'd3,
    ALU_OP_AND  = 4'd4,
    ALU_OP_SLL  = 4'd5,
    ALU_OP_SRL  = 4'd6,
    ALU_OP_SRA  = 4'd7,
    ALU_OP_SLT  = 4'd8,
    ALU_OP_SLTU = 4'd9
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // RV32I encodings
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Normal funct7 and the alternate one for SUB / SRA
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

/* rvj1_exec_if.sv */
`timescale 1ns/1ns

interface rvj1_exec_if;

  // One issued operation, valid for a single cycle
  logic                  valid;
  rvj1_defines::alu_op_e sel;
  rvj1_defines::word_t   op_a;
  rvj1_defines::word_t   op_b;
  // Destination, read back by the issue stage for its write-back pipe
  rvj1_defines::reg_idx_t rd;

  // Issue side drives everything
  modport issue (
    output valid,
    output sel,
    output op_a,
    output op_b,
    output rd
  );

  // ALU only needs the operation and operands
  modport alu (
    input valid,
    input sel,
    input op_a,
    input op_b
  );

endinterface

/* rvj1_decoder.sv */
`timescale 1ns/1ns

module rvj1_decoder (
  input  rvj1_defines::word_t    instr_i,
  output rvj1_defines::alu_op_e  sel_o,
  output rvj1_defines::reg_idx_t rs1_o,
  output rvj1_defines::reg_idx_t rs2_o,
  output rvj1_defines::reg_idx_t rd_o,
  output rvj1_defines::word_t    imm_o,
  output logic                   use_imm_o,
  output logic                   illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_op_imm;
  logic       f7_base;
  logic       f7_alt;
  logic       alt_allowed;
  logic       f7_checked;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // I-type immediate, sign extended from bit 31
  assign imm_o = {{(rvj1_defines::XLEN-12){instr_i[31]}}, instr_i[31:20]};

  assign is_op     = (opcode == rvj1_defines::OPC_OP);
  assign is_op_imm = (opcode == rvj1_defines::OPC_OP_IMM);
  assign use_imm_o = is_op_imm;

  assign f7_base = (funct7 == rvj1_defines::FUNCT7_BASE);
  assign f7_alt  = (funct7 == rvj1_defines::FUNCT7_ALT);

  // SUB only in OP, SRA/SRAI in both
  assign alt_allowed = (is_op && (funct3 == rvj1_defines::F3_ADD_SUB)) ||
                       (funct3 == rvj1_defines::F3_SRL_SRA);
  // funct7 is an immediate field for OP-IMM except for shifts
  assign f7_checked  = is_op ||
                       (funct3 == rvj1_defines::F3_SLL) ||
                       (funct3 == rvj1_defines::F3_SRL_SRA);

  assign illegal_o = !(is_op || is_op_imm) ||
                     (f7_checked && !(f7_base || (f7_alt && alt_allowed)));

  // Operation select from funct3, alt bit picks SUB/SRA
  always_comb
  begin
    case (funct3)
      rvj1_defines::F3_ADD_SUB:
        sel_o = (is_op && f7_alt) ? rvj1_defines::ALU_OP_SUB : rvj1_defines::ALU_OP_ADD;
      rvj1_defines::F3_SLL:     sel_o = rvj1_defines::ALU_OP_SLL;
      rvj1_defines::F3_SLT:     sel_o = rvj1_defines::ALU_OP_SLT;
      rvj1_defines::F3_SLTU:    sel_o = rvj1_defines::ALU_OP_SLTU;
      rvj1_defines::F3_XOR:     sel_o = rvj1_defines::ALU_OP_XOR;
      rvj1_defines::F3_SRL_SRA:
        sel_o = f7_alt ? rvj1_defines::ALU_OP_SRA : rvj1_defines::ALU_OP_SRL;
      rvj1_defines::F3_OR:      sel_o = rvj1_defines::ALU_OP_OR;
      default:                  sel_o = rvj1_defines::ALU_OP_AND;
    endcase
  end

endmodule

/* rvj1_regfile.sv */
`timescale 1ns/1ns

module rvj1_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  rvj1_defines::reg_idx_t raddr_a_i,
  input  rvj1_defines::reg_idx_t raddr_b_i,
  output rvj1_defines::word_t    rdata_a_o,
  output rvj1_defines::word_t    rdata_b_o,
  input  logic                   we_i,
  input  rvj1_defines::reg_idx_t waddr_i,
  input  rvj1_defines::word_t    wdata_i
);

  localparam int NUM_REGS = 2 ** rvj1_defines::REG_ADDR_W;

  // x0 has no storage
  rvj1_defines::word_t regs_q [1:NUM_REGS-1];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    // Writes to x0 dropped here
    else if (we_i && (waddr_i != '0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports, combinational
  ////////////////////////////////////////////////////////////

  // x0 always reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rvj1_issue.sv */
`timescale 1ns/1ns

module rvj1_issue (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  // From decoder
  input  rvj1_defines::alu_op_e  sel_i,
  input  rvj1_defines::reg_idx_t rs1_i,
  input  rvj1_defines::reg_idx_t rs2_i,
  input  rvj1_defines::reg_idx_t rd_i,
  input  rvj1_defines::word_t    imm_i,
  input  logic                   use_imm_i,
  input  logic                   illegal_i,
  // Register file read side
  output rvj1_defines::reg_idx_t raddr_a_o,
  output rvj1_defines::reg_idx_t raddr_b_o,
  input  rvj1_defines::word_t    rdata_a_i,
  input  rvj1_defines::word_t    rdata_b_i,
  // Result sitting in the ALU register
  input  rvj1_defines::word_t    alu_res_i,
  rvj1_exec_if.issue             exec,
  output logic                   wb_valid_o,
  output logic                   illegal_o,
  output rvj1_defines::reg_idx_t wb_rd_o
);

  logic                   fwd_a;
  logic                   fwd_b;
  rvj1_defines::word_t    opnd_a;
  rvj1_defines::word_t    opnd_b;
  logic                   wb_valid_q;
  logic                   illegal_q;
  rvj1_defines::reg_idx_t wb_rd_q;

  assign raddr_a_o = rs1_i;
  assign raddr_b_o = rs2_i;

  ////////////////////////////////////////////////////////////
  // Operand select with forwarding
  ////////////////////////////////////////////////////////////

  // Pending write-back not yet in the register file
  assign fwd_a = wb_valid_q && (wb_rd_q == rs1_i) && (rs1_i != '0);
  assign fwd_b = wb_valid_q && (wb_rd_q == rs2_i) && (rs2_i != '0);

  assign opnd_a = fwd_a ? alu_res_i : rdata_a_i;
  assign opnd_b = fwd_b ? alu_res_i : rdata_b_i;

  // Illegal instructions never reach the ALU
  assign exec.valid = instr_valid_i && !illegal_i;
  assign exec.sel   = sel_i;
  assign exec.op_a  = opnd_a;
  // OP-IMM takes the immediate for op_b
  assign exec.op_b  = use_imm_i ? imm_i : opnd_b;
  assign exec.rd    = rd_i;

  ////////////////////////////////////////////////////////////
  // Write-back control pipe, one cycle like the ALU
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wb_valid_q <= 1'b0;
      illegal_q  <= 1'b0;
    end
    else
    begin
      wb_valid_q <= exec.valid;
      illegal_q  <= instr_valid_i && illegal_i;
    end
  end

  // Destination index, only meaningful with wb_valid
  always_ff @(posedge clk_i)
  begin
    wb_rd_q <= exec.rd;
  end

  assign wb_valid_o = wb_valid_q;
  assign illegal_o  = illegal_q;
  assign wb_rd_o    = wb_rd_q;

endmodule

/* rvj1_alu.sv */
`timescale 1ns/1ns

module rvj1_alu (
  input  logic                clk_i,
  input  logic                rst_n_i,
  rvj1_exec_if.alu            exec,
  output rvj1_defines::word_t res_o
);

  logic [rvj1_defines::SHAMT_W-1:0] shamt;
  logic                             lt_signed;
  logic                             lt_unsigned;
  rvj1_defines::word_t              res_d;
  rvj1_defines::word_t              res_q;

  ////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////

  // Shift amount truncated to five bits
  assign shamt = exec.op_b[rvj1_defines::SHAMT_W-1:0];

  // Compares for SLT / SLTU
  assign lt_signed   = $signed(exec.op_a) < $signed(exec.op_b);
  assign lt_unsigned = exec.op_a < exec.op_b;

  always_comb
  begin
    case (exec.sel)
      rvj1_defines::ALU_OP_ADD:  res_d = exec.op_a + exec.op_b;
      rvj1_defines::ALU_OP_SUB:  res_d = exec.op_a - exec.op_b;
      rvj1_defines::ALU_OP_XOR:  res_d = exec.op_a ^ exec.op_b;
      rvj1_defines::ALU_OP_OR:   res_d = exec.op_a | exec.op_b;
      rvj1_defines::ALU_OP_AND:  res_d = exec.op_a & exec.op_b;
      rvj1_defines::ALU_OP_SLL:  res_d = exec.op_a << shamt;
      rvj1_defines::ALU_OP_SRL:  res_d = exec.op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      rvj1_defines::ALU_OP_SRA:  res_d = $signed(exec.op_a) >>> shamt;
      // Zero extended flag
      rvj1_defines::ALU_OP_SLT:  res_d = {{(rvj1_defines::XLEN-1){1'b0}}, lt_signed};
      rvj1_defines::ALU_OP_SLTU: res_d = {{(rvj1_defines::XLEN-1){1'b0}}, lt_unsigned};
      default:                   res_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Holds the last result while no operation is issued
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      res_q <= '0;
    end
    else if (exec.valid)
    begin
      res_q <= res_d;
    end
  end

  assign res_o = res_q;

endmodule

/* rvj1_exec_top.sv */
`timescale 1ns/1ns

module rvj1_exec_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  rvj1_defines::word_t    instr_i,
  output logic                   wb_valid_o,
  output rvj1_defines::reg_idx_t wb_rd_o,
  output rvj1_defines::word_t    wb_data_o,
  output logic                   illegal_o
);

  // Decoder outputs
  rvj1_defines::alu_op_e  dec_sel;
  rvj1_defines::reg_idx_t dec_rs1;
  rvj1_defines::reg_idx_t dec_rs2;
  rvj1_defines::reg_idx_t dec_rd;
  rvj1_defines::word_t    dec_imm;
  logic                   dec_use_imm;
  logic                   dec_illegal;

  // Register file read side
  rvj1_defines::reg_idx_t rf_raddr_a;
  rvj1_defines::reg_idx_t rf_raddr_b;
  rvj1_defines::word_t    rf_rdata_a;
  rvj1_defines::word_t    rf_rdata_b;

  // Issued operation toward the ALU
  rvj1_exec_if exec_bus ();

  rvj1_decoder i_decoder (
    .instr_i   (instr_i),
    .sel_o     (dec_sel),
    .rs1_o     (dec_rs1),
    .rs2_o     (dec_rs2),
    .rd_o      (dec_rd),
    .imm_o     (dec_imm),
    .use_imm_o (dec_use_imm),
    .illegal_o (dec_illegal)
  );

  rvj1_issue i_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .sel_i         (dec_sel),
    .rs1_i         (dec_rs1),
    .rs2_i         (dec_rs2),
    .rd_i          (dec_rd),
    .imm_i         (dec_imm),
    .use_imm_i     (dec_use_imm),
    .illegal_i     (dec_illegal),
    .raddr_a_o     (rf_raddr_a),
    .raddr_b_o     (rf_raddr_b),
    .rdata_a_i     (rf_rdata_a),
    .rdata_b_i     (rf_rdata_b),
    .alu_res_i     (wb_data_o),
    .exec          (exec_bus),
    .wb_valid_o    (wb_valid_o),
    .illegal_o     (illegal_o),
    .wb_rd_o       (wb_rd_o)
  );

  // Write port fed straight from the write-back outputs
  rvj1_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (wb_valid_o),
    .waddr_i   (wb_rd_o),
    .wdata_i   (wb_data_o)
  );

  rvj1_alu i_alu (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .exec    (exec_bus),
    .res_o   (wb_data_o)
  );

endmodule

/* tb_rvj1_exec_assert.sv */
`timescale 1ns/1ns

module tb_rvj1_exec_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic instr_valid_i,
  input logic wb_valid_i,
  input logic illegal_i
);

  // Count of failed properties
  int num_errors = 0;

  ////////////////////////////////////////////////////////////
  // Write-back output properties
  ////////////////////////////////////////////////////////////

  // Never both at once
  property p_exclusive;
    @(posedge clk_i) disable iff (!rst_n_i)
      !(wb_valid_i && illegal_i);
  endproperty

  // Each response traces back to an accepted word
  property p_needs_instr;
    @(posedge clk_i) disable iff (!rst_n_i)
      (wb_valid_i || illegal_i) |-> $past(instr_valid_i);
  endproperty

  // Quiet while reset is applied
  property p_reset_quiet;
    @(posedge clk_i)
      !$past(rst_n_i) |-> !(wb_valid_i || illegal_i);
  endproperty

  a_exclusive: assert property (p_exclusive)
  else
  begin
    num_errors = num_errors + 1;
    $error("wb_valid and illegal high in the same cycle");
  end

  a_needs_instr: assert property (p_needs_instr)
  else
  begin
    num_errors = num_errors + 1;
    $error("Response without a valid instruction one cycle earlier");
  end

  a_reset_quiet: assert property (p_reset_quiet)
  else
  begin
    num_errors = num_errors + 1;
    $error("Response output high during reset");
  end

endmodule

/* tb_rvj1_exec.sv */
`timescale 1ns/1ns

module tb_rvj1_exec;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 2;
  // Immediate loads, operand spreading, random R-type, directed sequences under 80 slots
  localparam int NUM_SLOTS  = 31 + 3 * 31 + 40 + 80;
  localparam int TIMEOUT_NS = (RST_CYCLES + NUM_SLOTS) * CLK_PERIOD + 50 * CLK_PERIOD;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   instr_valid_i;
  rvj1_defines::word_t    instr_i;
  logic                   wb_valid_o;
  rvj1_defines::reg_idx_t wb_rd_o;
  rvj1_defines::word_t    wb_data_o;
  logic                   illegal_o;

  // Reference register file, x0 never written
  rvj1_defines::word_t    model_regs [32];
  // Expected response of the slot issued one cycle earlier
  logic                   exp_wb;
  logic                   exp_ill;
  rvj1_defines::reg_idx_t exp_rd;
  rvj1_defines::word_t    exp_data;
  integer                 seed;

  rvj1_exec_top i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o)
  );

  bind rvj1_exec_top tb_rvj1_exec_assert i_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .illegal_i     (illegal_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped");
  endtask

  // Compare outputs against the previous slot
  task automatic check_slot();
    assert ((wb_valid_o === exp_wb) && (illegal_o === exp_ill))
    else
    begin
      report_failure($sformatf("CHECK FAILED at %0t ns: wb_valid %b illegal %b, expected %b %b",
                               $time, wb_valid_o, illegal_o, exp_wb, exp_ill));
    end
    if (exp_wb)
    begin
      assert ((wb_rd_o === exp_rd) && (wb_data_o === exp_data))
      else
      begin
        report_failure($sformatf("CHECK FAILED at %0t ns: x%0d = %h, expected x%0d = %h",
                                 $time, wb_rd_o, wb_data_o, exp_rd, exp_data));
      end
    end
  endtask

  // RV32I result rules, SLT by sign bits, SRA by filling from bit 31
  function automatic rvj1_defines::word_t ref_result(input logic [2:0] f3, input logic alt,
                                                     input rvj1_defines::word_t a,
                                                     input rvj1_defines::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000:  ref_result = alt ? (a - b) : (a + b);
      3'b001:  ref_result = a << sh;
      3'b010:  ref_result = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'b011:  ref_result = {31'd0, a < b};
      3'b100:  ref_result = a ^ b;
      3'b101:  ref_result = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
      3'b110:  ref_result = a | b;
      default: ref_result = a & b;
    endcase
  endfunction

  // One slot: check last response, then drive at posedge + 1
  task automatic drive_slot(input logic valid, input rvj1_defines::word_t instr,
                            input logic wb, input logic ill,
                            input rvj1_defines::reg_idx_t rd, input rvj1_defines::word_t data);
    @(posedge clk_i);
    #1;
    check_slot();
    instr_valid_i = valid;
    instr_i       = instr;
    exp_wb        = wb;
    exp_ill       = ill;
    exp_rd        = rd;
    exp_data      = data;
  endtask

  // Encode one OP or OP-IMM word, predict it and drive it
  task automatic issue_instr(input logic is_imm, input logic [2:0] f3, input logic alt,
                             input rvj1_defines::reg_idx_t rd, input rvj1_defines::reg_idx_t rs1,
                             input rvj1_defines::reg_idx_t rs2, input logic [11:0] imm);
    rvj1_defines::word_t instr;
    rvj1_defines::word_t op_b;
    rvj1_defines::word_t result;
    if (is_imm)
    begin
      // Shift immediates carry funct7 in imm[11:5]
      instr = {imm, rs1, f3, rd, rvj1_defines::OPC_OP_IMM};
      op_b  = {{20{imm[11]}}, imm};
    end
    else
    begin
      instr = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rvj1_defines::OPC_OP};
      op_b  = model_regs[rs2];
    end
    result = ref_result(f3, alt, model_regs[rs1], op_b);
    drive_slot(1'b1, instr, 1'b1, 1'b0, rd, result);
    if (rd != '0)
    begin
      model_regs[rd] = result;
    end
  endtask

  task automatic issue_illegal(input rvj1_defines::word_t instr);
    drive_slot(1'b1, instr, 1'b0, 1'b1, '0, '0);
  endtask

  // Valid low with random junk on the bus
  task automatic idle_slot();
    drive_slot(1'b0, $random(seed), 1'b0, 1'b0, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_imm_ops();
    logic [2:0]          f3_list [6];
    rvj1_defines::word_t rnd;
    f3_list = '{rvj1_defines::F3_ADD_SUB, rvj1_defines::F3_XOR, rvj1_defines::F3_OR,
                rvj1_defines::F3_AND, rvj1_defines::F3_SLT, rvj1_defines::F3_SLTU};
    for (int i = 0; i < 31; i++)
    begin
      rnd = $random(seed);
      issue_instr(1'b1, f3_list[i % 6], 1'b0, rvj1_defines::reg_idx_t'(i + 1), '0, '0,
                  rnd[11:0]);
    end
  endtask

  task automatic test_reg_ops();
    logic [2:0]             op_f3 [10];
    logic                   op_alt [10];
    rvj1_defines::word_t    rnd;
    rvj1_defines::reg_idx_t r;
    op_f3  = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b001, 3'b101, 3'b101, 3'b010, 3'b011};
    op_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    // Spread random bits across all 32 of each register
    for (int i = 1; i < 32; i++)
    begin
      rnd = $random(seed);
      r   = rvj1_defines::reg_idx_t'(i);
      issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, r, '0, '0, rnd[11:0]);
      issue_instr(1'b1, rvj1_defines::F3_SLL, 1'b0, r, r, '0, {7'd0, 1'b1, rnd[15:12]});
      issue_instr(1'b1, rvj1_defines::F3_XOR, 1'b0, r, r, '0, rnd[31:20]);
    end
    for (int i = 0; i < 40; i++)
    begin
      rnd = $random(seed);
      issue_instr(1'b0, op_f3[i % 10], op_alt[i % 10], rnd[4:0], rnd[9:5], rnd[14:10], '0);
    end
    // Shift amount 37 truncates to 5, then SRAI / SRLI
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd30, 5'd0, 5'd0, 12'd37);
    issue_instr(1'b0, rvj1_defines::F3_SLL, 1'b0, 5'd31, 5'd28, 5'd30, '0);
    issue_instr(1'b0, rvj1_defines::F3_SRL_SRA, 1'b1, 5'd27, 5'd26, 5'd30, '0);
    issue_instr(1'b1, rvj1_defines::F3_SRL_SRA, 1'b1, 5'd29, 5'd1, 5'd0, 12'h40d);
    issue_instr(1'b1, rvj1_defines::F3_SRL_SRA, 1'b0, 5'd25, 5'd2, 5'd0, 12'h007);
  endtask

  task automatic test_forwarding();
    rvj1_defines::word_t rnd;
    rnd = $random(seed);
    // Both sources from the in-flight result
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd10, 5'd0, 5'd0, rnd[11:0]);
    issue_instr(1'b0, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd11, 5'd10, 5'd10, '0);
    // rs1 only, then rs2 only
    issue_instr(1'b0, rvj1_defines::F3_XOR, 1'b0, 5'd12, 5'd11, 5'd3, '0);
    issue_instr(1'b0, rvj1_defines::F3_ADD_SUB, 1'b1, 5'd13, 5'd4, 5'd12, '0);
    // Independent predecessor
    issue_instr(1'b1, rvj1_defines::F3_OR, 1'b0, 5'd14, 5'd0, 5'd0, rnd[23:12]);
    issue_instr(1'b0, rvj1_defines::F3_AND, 1'b0, 5'd15, 5'd13, 5'd12, '0);
    // x0 as destination never forwards
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd0, 5'd0, 5'd0, 12'h5a5);
    issue_instr(1'b0, rvj1_defines::F3_OR, 1'b0, 5'd16, 5'd0, 5'd0, '0);
    // One idle slot, value already in the register file
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd17, 5'd0, 5'd0, rnd[31:20]);
    idle_slot();
    issue_instr(1'b0, rvj1_defines::F3_ADD_SUB, 1'b1, 5'd18, 5'd17, 5'd10, '0);
    // Accumulating chain
    for (int i = 0; i < 8; i++)
    begin
      issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd19, 5'd19, 5'd0, 12'h123);
    end
  endtask

  task automatic test_x0_writes();
    // Result shows at the port with rd 0
    issue_instr(1'b1, rvj1_defines::F3_XOR, 1'b0, 5'd0, 5'd5, 5'd0, 12'h3c3);
    issue_instr(1'b0, rvj1_defines::F3_OR, 1'b0, 5'd6, 5'd0, 5'd5, '0);
    idle_slot();
    issue_instr(1'b0, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd7, 5'd0, 5'd0, '0);
    issue_instr(1'b1, rvj1_defines::F3_OR, 1'b0, 5'd8, 5'd0, 5'd0, '0);
  endtask

  task automatic test_slt_edges();
    rvj1_defines::reg_idx_t pa [8];
    rvj1_defines::reg_idx_t pb [8];
    pa = '{5'd1, 5'd2, 5'd2, 5'd3, 5'd3, 5'd1, 5'd1, 5'd0};
    pb = '{5'd2, 5'd1, 5'd3, 5'd2, 5'd4, 5'd1, 5'd0, 5'd1};
    // x1 most negative, x2 = -1, x3 = x4 = 1
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd1, 5'd0, 5'd0, 12'd1);
    issue_instr(1'b1, rvj1_defines::F3_SLL, 1'b0, 5'd1, 5'd1, 5'd0, 12'd31);
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd2, 5'd0, 5'd0, 12'hfff);
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd3, 5'd0, 5'd0, 12'd1);
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd4, 5'd0, 5'd0, 12'd1);
    for (int i = 0; i < 8; i++)
    begin
      issue_instr(1'b0, rvj1_defines::F3_SLT, 1'b0, 5'd5, pa[i], pb[i], '0);
      issue_instr(1'b0, rvj1_defines::F3_SLTU, 1'b0, 5'd6, pa[i], pb[i], '0);
    end
    issue_instr(1'b1, rvj1_defines::F3_SLT, 1'b0, 5'd7, 5'd1, 5'd0, 12'hfff);
    issue_instr(1'b1, rvj1_defines::F3_SLTU, 1'b0, 5'd8, 5'd3, 5'd0, 12'hfff);
    issue_instr(1'b1, rvj1_defines::F3_SLTU, 1'b0, 5'd9, 5'd2, 5'd0, 12'hfff);
    issue_instr(1'b1, rvj1_defines::F3_SLT, 1'b0, 5'd10, 5'd2, 5'd0, 12'h800);
  endtask

  task automatic test_illegal();
    // Distinct value left in the ALU result register
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd9, 5'd0, 5'd0, 12'h6b1);
    // LOAD, all-ones opcode, MUL, alt funct7 on XOR, on SLLI, bad SRLI funct7
    issue_illegal({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011});
    issue_illegal(32'hffffffff);
    issue_illegal({7'b0000001, 5'd2, 5'd1, rvj1_defines::F3_ADD_SUB, 5'd6, rvj1_defines::OPC_OP});
    issue_illegal({rvj1_defines::FUNCT7_ALT, 5'd2, 5'd1, rvj1_defines::F3_XOR, 5'd6,
                   rvj1_defines::OPC_OP});
    issue_illegal({rvj1_defines::FUNCT7_ALT, 5'd3, 5'd1, rvj1_defines::F3_SLL, 5'd6,
                   rvj1_defines::OPC_OP_IMM});
    issue_illegal({7'b0000001, 5'd3, 5'd1, rvj1_defines::F3_SRL_SRA, 5'd5,
                   rvj1_defines::OPC_OP_IMM});
    // Reader right behind an illegal x5 target sees the old x5
    issue_instr(1'b1, rvj1_defines::F3_ADD_SUB, 1'b0, 5'd7, 5'd5, 5'd0, 12'd0);
    issue_instr(1'b0, rvj1_defines::F3_OR, 1'b0, 5'd8, 5'd6, 5'd0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    seed          = 32'h6138;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    exp_wb        = 1'b0;
    exp_ill       = 1'b0;
    exp_rd        = '0;
    exp_data      = '0;
    for (int r = 0; r < 32; r++)
    begin
      model_regs[r] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_imm_ops();
    test_reg_ops();
    test_forwarding();
    test_x0_writes();
    test_slt_edges();
    test_illegal();
    // Drain the last response
    idle_slot();
    idle_slot();
    if (i_dut.i_assert.num_errors != 0)
    begin
      report_failure("Bound assertions on the write-back outputs failed");
    end
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    report_failure($sformatf("Watchdog timeout after %0d ns, tests did not complete",
                             TIMEOUT_NS));
  end

endmodule

/* files.f */
rvj1_defines.sv
rvj1_exec_if.sv
rvj1_decoder.sv
rvj1_regfile.sv
rvj1_issue.sv
rvj1_alu.sv
rvj1_exec_top.sv
tb_rvj1_exec_assert.sv
tb_rvj1_exec.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_rvj1_exec \
  -f files.f -Mdir obj_dir -o sim_tb_rvj1_exec
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_tb_rvj1_exec
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
